// ==== build.f ====
rtl/periph_pkg.sv
rtl/addr_decoder.sv
rtl/scratch_ram.sv
rtl/led_regs.sv
rtl/led_shifter.sv
rtl/switch_debounce.sv
rtl/periph_bus.sv
tests/tb_periph_bus.sv

// ==== rtl/addr_decoder.sv ====
module addr_decoder
  import periph_pkg::*;
(
  input  logic [31:0] addr,
  output region_t     region,
  output logic [7:0]  offset
);

  logic [31:0] ram_rel;
  logic [31:0] led_rel;
  logic [31:0] sw_rel;
  logic [31:0] rel;

  // unsigned wrap makes below-base addresses look huge
  assign ram_rel = addr - RAM_BASE;
  assign led_rel = addr - LED_BASE;
  assign sw_rel  = addr - SWITCH_BASE;

  always_comb begin
    region = REG_NONE;
    rel    = '0;
    if (ram_rel < RAM_SPAN) begin
      region = REG_RAM;
      rel    = ram_rel;
    end else if (led_rel < LED_SPAN) begin
      region = REG_LED;
      rel    = led_rel;
    end else if (sw_rel < SWITCH_SPAN) begin
      region = REG_SWITCH;
      rel    = sw_rel;
    end
  end

  // word index, byte bits dropped
  assign offset = rel[9:2];

endmodule

// ==== rtl/led_regs.sv ====
module led_regs
  import periph_pkg::*;
(
  input  logic         clk_100mhz,
  input  logic         rst,
  input  logic         sel,
  input  logic [3:0]   we,
  input  logic [1:0]   index,
  input  word_t        wdata,
  input  logic         busy,
  output word_t        rdata,
  output led_pattern_t pattern,
  output led_ctrl_t    ctrl
);

  localparam logic [1:0] PATTERN_IDX = LED_PATTERN_OFF[3:2];
  localparam logic [1:0] CTRL_IDX    = LED_CTRL_OFF[3:2];
  localparam logic [1:0] STATUS_IDX  = LED_STATUS_OFF[3:2];

  // both registers are 16 bits, so only lanes 0 and 1 matter
  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      pattern <= '0;
      ctrl    <= '0;
    end else if (sel) begin
      if (index == PATTERN_IDX) begin
        if (we[0]) pattern[7:0]  <= wdata[7:0];
        if (we[1]) pattern[15:8] <= wdata[15:8];
      end
      if (index == CTRL_IDX) begin
        if (we[0]) ctrl[7:0]  <= wdata[7:0];
        if (we[1]) ctrl[15:8] <= wdata[15:8];  // enable sits in bit 15
      end
    end
  end

  // readback
  always_ff @(posedge clk_100mhz) begin
    unique case (index)
      PATTERN_IDX: rdata <= {16'h0, pattern};
      CTRL_IDX:    rdata <= {16'h0, ctrl};
      STATUS_IDX:  rdata <= {31'h0, busy};
      default:     rdata <= '0;
    endcase
  end

endmodule

// ==== rtl/led_shifter.sv ====
module led_shifter
  import periph_pkg::*;
(
  input  logic         clk_100mhz,
  input  logic         rst,
  input  led_pattern_t pattern,
  input  led_ctrl_t    ctrl,
  output logic         led_clk,
  output logic         led_do,
  output logic         led_pen,
  output logic         busy
);

  typedef enum logic [1:0] {
    IDLE,
    SHIFT,
    LATCH
  } state_t;

  state_t       state;
  logic [14:0]  half_cnt;
  logic         half_done;
  logic         phase;     // high half of the led_clk period
  logic [3:0]   bit_cnt;
  led_pattern_t shreg;

  assign half_done = (half_cnt >= ctrl.half_period);

  //////////////////////////////////////////////////
  // frame fsm

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      state    <= IDLE;
      half_cnt <= '0;
      phase    <= 1'b0;
      bit_cnt  <= '0;
      shreg    <= '0;
    end else begin
      unique case (state)
        IDLE: begin
          half_cnt <= '0;
          phase    <= 1'b0;
          if (ctrl.enable) begin
            shreg   <= pattern;  // frame start
            bit_cnt <= '0;
            state   <= SHIFT;
          end
        end
        SHIFT: begin
          if (!half_done) begin
            half_cnt <= half_cnt + 15'd1;
          end else begin
            half_cnt <= '0;
            phase    <= ~phase;
            if (phase) begin  // falling edge, move to the next bit
              if (bit_cnt == 4'd15) begin
                shreg <= '0;
                state <= LATCH;
              end else begin
                shreg   <= shreg << 1;
                bit_cnt <= bit_cnt + 4'd1;
              end
            end
          end
        end
        LATCH: begin
          if (!half_done) begin
            half_cnt <= half_cnt + 15'd1;
          end else begin
            half_cnt <= '0;
            phase    <= ~phase;
            if (phase) begin  // one full period of led_pen done
              if (ctrl.enable) begin
                shreg   <= pattern;
                bit_cnt <= '0;
                state   <= SHIFT;
              end else begin
                state <= IDLE;
              end
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign led_clk = (state == SHIFT) && phase;
  assign led_do  = shreg[15];  // msb first
  assign led_pen = (state == LATCH);
  assign busy    = (state != IDLE);

endmodule

// ==== rtl/periph_bus.sv ====
module periph_bus
  import periph_pkg::*;
#(
  parameter int RAM_WORDS       = 256,
  parameter int DEBOUNCE_CYCLES = 1000
) (
  input  logic        clk_100mhz,
  input  logic        rst,
  input  bus_req_t    req,
  output bus_rsp_t    rsp,
  input  logic [15:0] switch,
  output logic        led_clk,
  output logic        led_do,
  output logic        led_pen
);

  region_t      region;
  region_t      region_q;
  logic [7:0]   offset;
  logic         access;
  logic         ready_q;
  word_t        ram_rdata;
  word_t        led_rdata;
  word_t        switch_rdata;
  led_pattern_t pattern;
  led_ctrl_t    ctrl;
  logic         busy;
  logic [15:0]  switch_stable;

  assign access = req.rd | (|req.we);

  addr_decoder u_addr_decoder (
    .addr   (req.addr),
    .region (region),
    .offset (offset)
  );

  //////////////////////////////////////////////////
  // windows

  scratch_ram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_scratch_ram (
    .clk_100mhz (clk_100mhz),
    .sel        (access && region == REG_RAM),
    .rd         (req.rd),
    .we         (req.we),
    .index      (offset),
    .wdata      (req.wdata),
    .rdata      (ram_rdata)
  );

  led_regs u_led_regs (
    .clk_100mhz (clk_100mhz),
    .rst        (rst),
    .sel        (access && region == REG_LED),
    .we         (req.we),
    .index      (offset[1:0]),
    .wdata      (req.wdata),
    .busy       (busy),
    .rdata      (led_rdata),
    .pattern    (pattern),
    .ctrl       (ctrl)
  );

  led_shifter u_led_shifter (
    .clk_100mhz (clk_100mhz),
    .rst        (rst),
    .pattern    (pattern),
    .ctrl       (ctrl),
    .led_clk    (led_clk),
    .led_do     (led_do),
    .led_pen    (led_pen),
    .busy       (busy)
  );

  switch_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_switch_debounce (
    .clk_100mhz (clk_100mhz),
    .rst        (rst),
    .switch     (switch),
    .stable     (switch_stable)
  );

  //////////////////////////////////////////////////
  // response

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      ready_q  <= 1'b0;
      region_q <= REG_NONE;
    end else begin
      ready_q <= access;  // every access completes in one cycle
      if (access) region_q <= region;
    end
  end

  always_ff @(posedge clk_100mhz) begin
    switch_rdata <= {16'h0, switch_stable};
  end

  always_comb begin
    rsp.ready = ready_q;
    unique case (region_q)
      REG_RAM:    rsp.rdata = ram_rdata;
      REG_LED:    rsp.rdata = led_rdata;
      REG_SWITCH: rsp.rdata = switch_rdata;
      default:    rsp.rdata = '0;  // unmapped reads as zero
    endcase
  end

endmodule

// ==== rtl/periph_pkg.sv ====
package periph_pkg;

  //////////////////////////////////////////////////
  // bus types

  typedef logic [31:0] word_t;

  // master side, one access per request
  typedef struct packed {
    logic [31:0] addr;
    word_t       wdata;
    logic        rd;
    logic [3:0]  we;    // one enable per byte lane
  } bus_req_t;

  typedef struct packed {
    word_t rdata;
    logic  ready;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    REG_RAM,
    REG_LED,
    REG_SWITCH,
    REG_NONE
  } region_t;

  //////////////////////////////////////////////////
  // address map

  localparam logic [31:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [31:0] RAM_SPAN    = 32'h0000_0400;  // 256 words
  localparam logic [31:0] LED_BASE    = 32'h0000_0400;
  localparam logic [31:0] LED_SPAN    = 32'h0000_0010;
  localparam logic [31:0] SWITCH_BASE = 32'h0000_0500;
  localparam logic [31:0] SWITCH_SPAN = 32'h0000_0004;  // single word

  // byte offsets inside the led window
  localparam logic [3:0] LED_PATTERN_OFF = 4'h0;
  localparam logic [3:0] LED_CTRL_OFF    = 4'h4;
  localparam logic [3:0] LED_STATUS_OFF  = 4'h8;

  //////////////////////////////////////////////////
  // led types

  typedef logic [15:0] led_pattern_t;

  typedef struct packed {
    logic        enable;
    logic [14:0] half_period;  // half led_clk period minus one, in clocks
  } led_ctrl_t;

endpackage

// ==== rtl/scratch_ram.sv ====
module scratch_ram
  import periph_pkg::*;
#(
  parameter int RAM_WORDS = 256
) (
  input  logic       clk_100mhz,
  input  logic       sel,
  input  logic       rd,
  input  logic [3:0] we,
  input  logic [7:0] index,
  input  word_t      wdata,
  output word_t      rdata
);

  word_t mem [RAM_WORDS];

  //////////////////////////////////////////////////
  // byte lane writes

  always_ff @(posedge clk_100mhz) begin
    if (sel) begin
      for (int b = 0; b < 4; b++) begin
        if (we[b]) begin
          mem[index][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // registered read

  always_ff @(posedge clk_100mhz) begin
    if (sel && rd) begin
      rdata <= mem[index];  // valid the cycle after
    end
  end

endmodule

// ==== rtl/switch_debounce.sv ====
module switch_debounce #(
  parameter int DEBOUNCE_CYCLES = 1000
) (
  input  logic        clk_100mhz,
  input  logic        rst,
  input  logic [15:0] switch,
  output logic [15:0] stable
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);
  localparam logic [CNT_W-1:0] LIMIT = CNT_W'(DEBOUNCE_CYCLES - 1);

  logic [15:0]      sync1;
  logic [15:0]      sync2;
  logic [15:0]      candidate;
  logic [CNT_W-1:0] cnt;

  //////////////////////////////////////////////////
  // two stage synchronizer

  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      sync1 <= '0;
      sync2 <= '0;
    end else begin
      sync1 <= switch;
      sync2 <= sync1;
    end
  end

  // any change restarts the count
  always_ff @(posedge clk_100mhz) begin
    if (rst) begin
      candidate <= '0;
      cnt       <= '0;
      stable    <= '0;
    end else if (sync2 != candidate) begin
      candidate <= sync2;
      cnt       <= '0;
    end else if (cnt < LIMIT) begin
      cnt <= cnt + 1'b1;
    end else begin
      stable <= candidate;  // held long enough
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_periph_bus -f build.f

if ./obj_dir/Vtb_periph_bus | tee /dev/stderr | grep "Result: PASSED" > /dev/null; then
  echo "simulation ok"
else
  echo "simulation failed"
  exit 1
fi

// ==== tests/periph_stim.txt ====
# W addr data mask | R addr expected | S switches | F frame | D cycles
# all fields hex except the D cycle count, which is decimal
W 00000000 11223344 f
W 00000004 55667788 f
W 000001fc cafef00d f
W 000003fc 0badc0de f
R 00000000 11223344
R 000003fc 0badc0de
W 00000004 000000aa 1
W 00000004 00ee0000 4
R 00000004 55ee77aa
R 000001fc cafef00d
W 00000400 0000a55a 3
W 00000400 000000c3 1
R 00000400 0000a5c3
W 00000404 00008001 3
R 00000404 00008001
R 00000408 00000001
W 00000408 ffffffff f
W 00000600 12345678 f
R 00000600 00000000
R 00000408 00000001
R 00000400 0000a5c3
R 00000000 11223344
F a5c3
W 00000400 00003c96 3
F 3c96
W 00000404 00000000 3
D 150
R 00000408 00000000
D 100
R 00000408 00000000
S 1234
D 30
R 00000500 00001234
S ffff
D 4
S 1234
D 30
R 00000500 00001234
S a5c3
D 30
R 00000500 0000a5c3
R 00000504 00000000

// ==== tests/tb_periph_bus.sv ====
module tb_periph_bus
  import periph_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    DEBOUNCE_CYCLES = 16;
  localparam string STIM_FILE       = "tests/periph_stim.txt";

  logic         clk_100mhz;
  logic         rst;
  bus_req_t     req;
  bus_rsp_t     rsp;
  logic [15:0]  switch;
  logic         led_clk;
  logic         led_do;
  logic         led_pen;

  int           cycles        = 0;
  int           cycle_limit   = 0;
  logic         led_clk_q     = 1'b0;
  logic         led_pen_q     = 1'b0;
  led_pattern_t frame_shift   = '0;
  led_pattern_t last_frame    = '0;
  int           frame_count   = 0;
  logic         leds_on       = 1'b0;
  int           frames_at_off = 0;

  periph_bus #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_periph_bus (
    .clk_100mhz (clk_100mhz),
    .rst        (rst),
    .req        (req),
    .rsp        (rsp),
    .switch     (switch),
    .led_clk    (led_clk),
    .led_do     (led_do),
    .led_pen    (led_pen)
  );

  initial begin
    clk_100mhz = 1'b0;
    forever #5 clk_100mhz = ~clk_100mhz;
  end

  //////////////////////////////////////////////////
  // failure, compare tasks, timeout

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %08h expected %08h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_frame(input string name, input led_pattern_t got,
                             input led_pattern_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %04h expected %04h", name, got, exp);
      abort_run();
    end
  endtask

  always @(posedge clk_100mhz) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // frames captured mid cycle
  always @(negedge clk_100mhz) begin
    led_clk_q <= led_clk;
    led_pen_q <= led_pen;
    if (led_clk && !led_clk_q) frame_shift <= {frame_shift[14:0], led_do};
    if (led_pen && !led_pen_q) begin
      // only the frame in progress may still end after disable
      if (!leds_on && frame_count > frames_at_off) begin
        $display("led_pen pulsed again after the LEDs were disabled and the last frame ended");
        abort_run();
      end else begin
        last_frame  <= frame_shift;
        frame_count <= frame_count + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // stimulus file and bus

  task automatic next_command(input int fd, output logic [7:0] kind, output logic [31:0] a,
                              output logic [31:0] b, output logic [31:0] c, output bit found);
    logic [7:0]       tok;
    logic [8*128-1:0] rest;
    int               n;
    int               need;
    found = 1'b0;
    kind  = 8'h0;
    a     = '0;
    b     = '0;
    c     = '0;
    n     = 0;
    need  = 0;
    while (!found && $fscanf(fd, "%s", tok) == 1) begin
      case (tok)
        "#": n = $fgets(rest, fd);  // comment line
        "W": begin
          n     = $fscanf(fd, "%h %h %h", a, b, c);
          need  = 3;
          found = 1'b1;
        end
        "R": begin
          n     = $fscanf(fd, "%h %h", a, b);
          need  = 2;
          found = 1'b1;
        end
        "S", "F": begin
          n     = $fscanf(fd, "%h", a);
          need  = 1;
          found = 1'b1;
        end
        "D": begin
          n     = $fscanf(fd, "%d", a);
          need  = 1;
          found = 1'b1;
        end
        default: begin
          $display("unknown command '%s' in the stimulus file", tok);
          abort_run();
        end
      endcase
      kind = tok;
    end
    if (found && n != need) begin
      $display("stimulus line for command '%s' has missing fields", kind);
      abort_run();
    end
  endtask

  task automatic compute_limit();
    int          fd;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    bit          found;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      abort_run();
    end
    cycle_limit = 10;  // reset
    next_command(fd, kind, a, b, c, found);
    while (found) begin
      if (kind == "D") cycle_limit += int'(a);
      else if (kind == "F") cycle_limit += 200;
      else cycle_limit += 64;
      next_command(fd, kind, a, b, c, found);
    end
    $fclose(fd);
  endtask

  task automatic bus_access(input logic [31:0] addr, input word_t wdata, input logic rd,
                            input logic [3:0] we, output word_t rdata);
    @(posedge clk_100mhz);
    #1;
    if (rsp.ready) begin
      $display("ready was still high before the access at address %08h", addr);
      abort_run();
    end
    req.addr  = addr;
    req.wdata = wdata;
    req.rd    = rd;
    req.we    = we;
    @(posedge clk_100mhz);
    #1;
    if (!rsp.ready) begin
      $display("no ready from the DUT in the cycle after the access at address %08h", addr);
      abort_run();
    end
    rdata  = rsp.rdata;
    req.rd = 1'b0;  // drop right after ready
    req.we = 4'h0;
  endtask

  task automatic expect_frame(input led_pattern_t exp, input int frames);
    int target;
    target = frame_count + frames;
    while (frame_count < target) @(posedge clk_100mhz);
    check_frame("led_do frame", last_frame, exp);
  endtask

  //////////////////////////////////////////////////
  // main sequence

  initial begin
    int          fd;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    bit          found;
    word_t       rdata;
    logic        pattern_moved;
    logic [15:0] switch_held;
    int          switch_since;
    rst           = 1'b1;
    req           = '0;
    switch        = '0;
    pattern_moved = 1'b0;
    switch_held   = '0;
    switch_since  = 0;
    compute_limit();
    repeat (10) @(posedge clk_100mhz);
    #1 rst = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    next_command(fd, kind, a, b, c, found);
    while (found) begin
      case (kind)
        "W": begin
          bus_access(a, b, 1'b0, c[3:0], rdata);
          // enable is bit 15 of the control word
          if (a == LED_BASE + {28'h0, LED_CTRL_OFF} && c[1]) begin
            leds_on       = b[15];
            frames_at_off = frame_count;
          end
          if (a == LED_BASE + {28'h0, LED_PATTERN_OFF} && leds_on) pattern_moved = 1'b1;
        end
        "R": begin
          bus_access(a, '0, 1'b1, 4'h0, rdata);
          check_word($sformatf("rsp.rdata at %08h", a), rdata, b);
        end
        "S": begin
          if (cycles - switch_since < DEBOUNCE_CYCLES) begin
            // a short glitch must not reach the window
            bus_access(SWITCH_BASE, '0, 1'b1, 4'h0, rdata);
            check_word("rsp.rdata at the switch window", rdata, {16'h0, switch_held});
          end else begin
            switch_held = switch;
          end
          @(posedge clk_100mhz);
          #1 switch = a[15:0];
          switch_since = cycles;
        end
        "F": begin
          // a frame in progress at the rewrite still carries the old pattern
          expect_frame(a[15:0], pattern_moved ? 2 : 1);
          pattern_moved = 1'b0;
        end
        default: repeat (a) @(posedge clk_100mhz);
      endcase
      next_command(fd, kind, a, b, c, found);
    end
    $fclose(fd);
    $display("Result: PASSED");
    $finish;
  end

endmodule
